// ==== rtl/rdbuf_pkg.sv ====
// --------------------------------------------------------------------------
// fixed build: 256-bit CHI data into four 128-bit banks, 128-bit AXI R data
// flit holds only txnid, dataid, resperr and data, lowest field first
// --------------------------------------------------------------------------
`default_nettype none

package rdbuf_pkg;

    // data path widths
    localparam int CHI_DATA_W  = 256;
    localparam int BANK_DATA_W = 128;
    localparam int BANK_NUM    = 4;

    // flit and request fields
    localparam int TXNID_W     = 12;
    localparam int DATAID_W    = 2;
    localparam int RESP_W      = 2;
    localparam int ENTRY_NUM   = 8;
    localparam int ENTRY_IDX_W = 3;
    localparam int RID_W       = 4;
    localparam int BCOUNT_W    = 4;

    // queue depths
    localparam int RP_DEPTH = 4;
    localparam int RD_DEPTH = 4;

    // flit layout
    localparam int FLIT_TXNID_LSB  = 0;
    localparam int FLIT_DATAID_LSB = FLIT_TXNID_LSB + TXNID_W;
    localparam int FLIT_RESP_LSB   = FLIT_DATAID_LSB + DATAID_W;
    localparam int FLIT_DATA_LSB   = FLIT_RESP_LSB + RESP_W;
    localparam int FLIT_W          = FLIT_DATA_LSB + CHI_DATA_W;

    // dispatch entry is id, data, resp and last; pending adds the repeat count
    localparam int RD_ENTRY_W = RID_W + BANK_DATA_W + RESP_W + 1;
    localparam int RP_ENTRY_W = RD_ENTRY_W + BCOUNT_W;

    typedef logic [FLIT_W-1:0]      flit_t;
    typedef logic [TXNID_W-1:0]     txnid_t;
    typedef logic [DATAID_W-1:0]    dataid_t;
    typedef logic [RESP_W-1:0]      resp_t;
    typedef logic [RID_W-1:0]       rid_t;
    typedef logic [BCOUNT_W-1:0]    bcount_t;
    typedef logic [CHI_DATA_W-1:0]  chi_data_t;
    typedef logic [BANK_DATA_W-1:0] bank_data_t;

    // slot index, low bits of txnid
    typedef logic [ENTRY_IDX_W-1:0] entry_idx_t;

    // one bit per bank
    typedef logic [BANK_NUM-1:0]    ctmask_t;
    typedef logic [BANK_NUM-1:0]    bank_vec_t;

endpackage

`default_nettype wire

// ==== rtl/rdbuf_flit_decode.sv ====
// --------------------------------------------------------------------------
// ids are forwarded combinationally; bank strobes follow one cycle later
// only dataid 0 and 2 write, each covering a pair of banks
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module rdbuf_flit_decode (
    input  wire                    clk_i,
    input  wire                    rst_i,

    input  wire                    flit_valid_i,
    input  rdbuf_pkg::flit_t       flit_i,

    output logic                   flit_valid_o,
    output rdbuf_pkg::txnid_t      flit_txnid_o,
    output rdbuf_pkg::dataid_t     flit_dataid_o,

    output rdbuf_pkg::bank_vec_t   bank_wr_o,
    output rdbuf_pkg::entry_idx_t  wr_idx_o,
    output rdbuf_pkg::chi_data_t   wr_data_o,
    output rdbuf_pkg::resp_t       wr_resp_o
);

    rdbuf_pkg::txnid_t      flit_txnid;
    rdbuf_pkg::dataid_t     flit_dataid;
    rdbuf_pkg::resp_t       flit_resp;
    rdbuf_pkg::chi_data_t   flit_data;

    logic                   flit_valid_q;
    rdbuf_pkg::dataid_t     dataid_q;
    rdbuf_pkg::entry_idx_t  idx_q;
    rdbuf_pkg::chi_data_t   data_q;
    rdbuf_pkg::resp_t       resp_q;

    // field split
    assign flit_txnid  = flit_i[rdbuf_pkg::FLIT_TXNID_LSB  +: rdbuf_pkg::TXNID_W];
    assign flit_dataid = flit_i[rdbuf_pkg::FLIT_DATAID_LSB +: rdbuf_pkg::DATAID_W];
    assign flit_resp   = flit_i[rdbuf_pkg::FLIT_RESP_LSB   +: rdbuf_pkg::RESP_W];
    assign flit_data   = flit_i[rdbuf_pkg::FLIT_DATA_LSB   +: rdbuf_pkg::CHI_DATA_W];

    // to the address controller, same cycle
    assign flit_valid_o  = flit_valid_i;
    assign flit_txnid_o  = flit_txnid;
    assign flit_dataid_o = flit_dataid;

    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            flit_valid_q <= 1'b0;
        end else begin
            flit_valid_q <= flit_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (flit_valid_i) begin
            dataid_q <= flit_dataid;
            idx_q    <= flit_txnid[rdbuf_pkg::ENTRY_IDX_W-1:0];
            data_q   <= flit_data;
            resp_q   <= flit_resp;
        end
    end

    // dataid 0 -> banks 0/1, dataid 2 -> banks 2/3
    always_comb begin
        bank_wr_o = '0;
        if (flit_valid_q) begin
            case (dataid_q)
                2'd0:    bank_wr_o = 4'b0011;
                2'd2:    bank_wr_o = 4'b1100;
                default: bank_wr_o = '0;
            endcase
        end
    end

    assign wr_idx_o  = idx_q;
    assign wr_data_o = data_q;
    assign wr_resp_o = resp_q;

endmodule

`default_nettype wire

// ==== rtl/rdbuf_data_store.sv ====
// --------------------------------------------------------------------------
// request is accepted and packed combinationally; mask must be nonzero
// data banks are not cleared by reset, error codes read back as OKAY
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module rdbuf_data_store (
    input  wire                    clk_i,
    input  wire                    rst_i,

    input  rdbuf_pkg::bank_vec_t   bank_wr_i,
    input  rdbuf_pkg::entry_idx_t  wr_idx_i,
    input  rdbuf_pkg::chi_data_t   wr_data_i,
    input  rdbuf_pkg::resp_t       wr_resp_i,

    input  wire                    req_valid_i,
    input  rdbuf_pkg::entry_idx_t  req_idx_i,
    input  rdbuf_pkg::ctmask_t     req_ctmask_i,
    input  wire                    rp_full_i,

    output logic                   req_accept_o,
    output rdbuf_pkg::bank_data_t  beat_data_o,
    output rdbuf_pkg::resp_t       beat_resp_o
);

    rdbuf_pkg::bank_data_t  rd_data [rdbuf_pkg::BANK_NUM];
    rdbuf_pkg::resp_t       rd_resp [rdbuf_pkg::BANK_NUM];

    genvar b;

    generate
        for (b = 0; b < rdbuf_pkg::BANK_NUM; b = b + 1) begin : g_bank
            rdbuf_pkg::bank_data_t  data_mem [rdbuf_pkg::ENTRY_NUM];
            rdbuf_pkg::resp_t       resp_mem [rdbuf_pkg::ENTRY_NUM];

            // even bank takes the low half of the flit, odd bank the high half
            always_ff @(posedge clk_i) begin
                if (bank_wr_i[b]) begin
                    data_mem[wr_idx_i] <=
                        wr_data_i[(b % 2) * rdbuf_pkg::BANK_DATA_W +: rdbuf_pkg::BANK_DATA_W];
                end
            end

            always_ff @(posedge clk_i or posedge rst_i) begin
                if (rst_i) begin
                    for (int i = 0; i < rdbuf_pkg::ENTRY_NUM; i++) begin
                        resp_mem[i] <= '0;
                    end
                end else if (bank_wr_i[b]) begin
                    resp_mem[wr_idx_i] <= wr_resp_i;
                end
            end

            assign rd_data[b] = data_mem[req_idx_i];
            assign rd_resp[b] = resp_mem[req_idx_i];
        end
    endgenerate

    assign req_accept_o = req_valid_i & (|req_ctmask_i) & ~rp_full_i;

    // OR of every selected bank
    always_comb begin
        beat_data_o = '0;
        beat_resp_o = '0;
        for (int i = 0; i < rdbuf_pkg::BANK_NUM; i++) begin
            if (req_ctmask_i[i]) begin
                beat_data_o = beat_data_o | rd_data[i];
                beat_resp_o = beat_resp_o | rd_resp[i];
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/rdbuf_fifo.sv ====
// --------------------------------------------------------------------------
// no bypass: a pushed entry shows on data_o one cycle later
// push when full and pop when empty are ignored; DEPTH of 2 or more
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module rdbuf_fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 4
) (
    input  wire              clk_i,
    input  wire              rst_i,
    input  wire              push_i,
    input  wire              pop_i,
    input  wire [WIDTH-1:0]  data_i,
    output logic [WIDTH-1:0] data_o,
    output logic             empty_o,
    output logic             full_o
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             do_push;
    logic             do_pop;

    assign do_push = push_i & ~full_o;
    assign do_pop  = pop_i & ~empty_o;

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem[wr_ptr_q] <= data_i;
        end
    end

    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            // simultaneous push and pop leaves the count alone
            if (do_push && !do_pop) begin
                count_q <= count_q + 1'b1;
            end else if (do_pop && !do_push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    assign data_o  = mem[rd_ptr_q];
    assign empty_o = (count_q == '0);
    assign full_o  = (count_q == CNT_W'(DEPTH));

endmodule

`default_nettype wire

// ==== rtl/rdbuf_beat_issue.sv ====
// --------------------------------------------------------------------------
// each pending entry is sent bcount+1 times, one copy per cycle with room
// last is set on the final copy only, and only if the entry asked for it
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module rdbuf_beat_issue (
    input  wire                    clk_i,
    input  wire                    rst_i,

    input  wire                    push_i,
    input  rdbuf_pkg::bank_data_t  beat_data_i,
    input  rdbuf_pkg::resp_t       beat_resp_i,
    input  rdbuf_pkg::rid_t        beat_rid_i,
    input  wire                    beat_last_i,
    input  rdbuf_pkg::bcount_t     beat_bcount_i,
    output logic                   rp_full_o,

    input  wire                    r_ready_i,
    output logic                   r_valid_o,
    output rdbuf_pkg::rid_t        r_id_o,
    output rdbuf_pkg::bank_data_t  r_data_o,
    output rdbuf_pkg::resp_t       r_resp_o,
    output logic                   r_last_o
);

    logic [rdbuf_pkg::RP_ENTRY_W-1:0] rp_in;
    logic [rdbuf_pkg::RP_ENTRY_W-1:0] rp_out;
    logic                             rp_empty;
    logic                             rp_pop;

    rdbuf_pkg::bank_data_t  head_data;
    rdbuf_pkg::resp_t       head_resp;
    rdbuf_pkg::rid_t        head_rid;
    logic                   head_last;
    rdbuf_pkg::bcount_t     head_bcount;

    rdbuf_pkg::bcount_t     bcount_q;
    rdbuf_pkg::bcount_t     bcount_next;
    logic                   issue;
    logic                   done;

    logic [rdbuf_pkg::RD_ENTRY_W-1:0] rd_in;
    logic [rdbuf_pkg::RD_ENTRY_W-1:0] rd_out;
    logic                             rd_empty;
    logic                             rd_full;
    logic                             rd_pop;

    assign rp_in = {beat_bcount_i, beat_last_i, beat_rid_i, beat_resp_i, beat_data_i};

    rdbuf_fifo #(
        .WIDTH (rdbuf_pkg::RP_ENTRY_W),
        .DEPTH (rdbuf_pkg::RP_DEPTH)
    ) u_rp_fifo (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .push_i  (push_i),
        .pop_i   (rp_pop),
        .data_i  (rp_in),
        .data_o  (rp_out),
        .empty_o (rp_empty),
        .full_o  (rp_full_o)
    );

    assign {head_bcount, head_last, head_rid, head_resp, head_data} = rp_out;

    // zero in bcount_q marks the first copy of the head entry
    assign issue       = ~rp_empty & ~rd_full;
    assign bcount_next = (bcount_q == '0) ? head_bcount : bcount_q - 1'b1;
    assign done        = (bcount_next == '0);

    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            bcount_q <= '0;
        end else if (issue) begin
            bcount_q <= bcount_next;
        end
    end

    assign rp_pop = issue & done;
    assign rd_in  = {head_last & done, head_rid, head_resp, head_data};
    assign rd_pop = r_valid_o & r_ready_i;

    rdbuf_fifo #(
        .WIDTH (rdbuf_pkg::RD_ENTRY_W),
        .DEPTH (rdbuf_pkg::RD_DEPTH)
    ) u_rd_fifo (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .push_i  (issue),
        .pop_i   (rd_pop),
        .data_i  (rd_in),
        .data_o  (rd_out),
        .empty_o (rd_empty),
        .full_o  (rd_full)
    );

    assign r_valid_o = ~rd_empty;
    assign {r_last_o, r_id_o, r_resp_o, r_data_o} = rd_out;

endmodule

`default_nettype wire

// ==== rtl/rdbuf_top.sv ====
// --------------------------------------------------------------------------
// flit input has no back-pressure; requester holds req_valid_i until accept
// a flit seen in cycle n can be read by a request from cycle n+2
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module rdbuf_top (
    input  wire                    clk_i,
    input  wire                    rst_i,

    // CHI data flits
    input  wire                    flit_valid_i,
    input  rdbuf_pkg::flit_t       flit_i,
    output logic                   flit_valid_o,
    output rdbuf_pkg::txnid_t      flit_txnid_o,
    output rdbuf_pkg::dataid_t     flit_dataid_o,

    // read requests
    input  wire                    req_valid_i,
    input  rdbuf_pkg::entry_idx_t  req_idx_i,
    input  rdbuf_pkg::ctmask_t     req_ctmask_i,
    input  wire                    req_last_i,
    input  rdbuf_pkg::rid_t        req_rid_i,
    input  rdbuf_pkg::bcount_t     req_bcount_i,
    output logic                   req_accept_o,

    // AXI R channel
    input  wire                    r_ready_i,
    output logic                   r_valid_o,
    output rdbuf_pkg::rid_t        r_id_o,
    output rdbuf_pkg::bank_data_t  r_data_o,
    output rdbuf_pkg::resp_t       r_resp_o,
    output logic                   r_last_o
);

    rdbuf_pkg::bank_vec_t   bank_wr;
    rdbuf_pkg::entry_idx_t  wr_idx;
    rdbuf_pkg::chi_data_t   wr_data;
    rdbuf_pkg::resp_t       wr_resp;
    rdbuf_pkg::bank_data_t  beat_data;
    rdbuf_pkg::resp_t       beat_resp;
    logic                   rp_full;

    rdbuf_flit_decode u_flit_decode (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .flit_valid_i  (flit_valid_i),
        .flit_i        (flit_i),
        .flit_valid_o  (flit_valid_o),
        .flit_txnid_o  (flit_txnid_o),
        .flit_dataid_o (flit_dataid_o),
        .bank_wr_o     (bank_wr),
        .wr_idx_o      (wr_idx),
        .wr_data_o     (wr_data),
        .wr_resp_o     (wr_resp)
    );

    rdbuf_data_store u_data_store (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .bank_wr_i    (bank_wr),
        .wr_idx_i     (wr_idx),
        .wr_data_i    (wr_data),
        .wr_resp_i    (wr_resp),
        .req_valid_i  (req_valid_i),
        .req_idx_i    (req_idx_i),
        .req_ctmask_i (req_ctmask_i),
        .rp_full_i    (rp_full),
        .req_accept_o (req_accept_o),
        .beat_data_o  (beat_data),
        .beat_resp_o  (beat_resp)
    );

    // accept strobe doubles as the pending-queue push
    rdbuf_beat_issue u_beat_issue (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .push_i        (req_accept_o),
        .beat_data_i   (beat_data),
        .beat_resp_i   (beat_resp),
        .beat_rid_i    (req_rid_i),
        .beat_last_i   (req_last_i),
        .beat_bcount_i (req_bcount_i),
        .rp_full_o     (rp_full),
        .r_ready_i     (r_ready_i),
        .r_valid_o     (r_valid_o),
        .r_id_o        (r_id_o),
        .r_data_o      (r_data_o),
        .r_resp_o      (r_resp_o),
        .r_last_o      (r_last_o)
    );

endmodule

`default_nettype wire

// ==== test/rdbuf_ref.svh ====
// --------------------------------------------------------------------------
// bank model is written as soon as a flit is sent; requests that read a slot
// must start two cycles after the flit that wrote it
// --------------------------------------------------------------------------
`ifndef RDBUF_REF_SVH
`define RDBUF_REF_SVH

rdbuf_pkg::bank_data_t model_data [rdbuf_pkg::BANK_NUM][rdbuf_pkg::ENTRY_NUM];
rdbuf_pkg::resp_t      model_resp [rdbuf_pkg::BANK_NUM][rdbuf_pkg::ENTRY_NUM];

// error codes come out of reset as OKAY
task automatic model_clear();
    for (int b = 0; b < rdbuf_pkg::BANK_NUM; b++) begin
        for (int e = 0; e < rdbuf_pkg::ENTRY_NUM; e++) begin
            model_data[b][e] = '0;
            model_resp[b][e] = '0;
        end
    end
endtask

task automatic model_write(
    input rdbuf_pkg::txnid_t    txnid,
    input rdbuf_pkg::dataid_t   dataid,
    input rdbuf_pkg::resp_t     resp,
    input rdbuf_pkg::chi_data_t data
);
    rdbuf_pkg::entry_idx_t idx;
    int                    base;
    idx = txnid[rdbuf_pkg::ENTRY_IDX_W-1:0];
    // dataid 1 and 3 carry nothing for this buffer
    if (dataid == 2'd0 || dataid == 2'd2) begin
        base = (dataid == 2'd0) ? 0 : 2;
        model_data[base][idx]     = data[rdbuf_pkg::BANK_DATA_W-1:0];
        model_data[base + 1][idx] = data[rdbuf_pkg::CHI_DATA_W-1:rdbuf_pkg::BANK_DATA_W];
        model_resp[base][idx]     = resp;
        model_resp[base + 1][idx] = resp;
    end
endtask

// expected R data and resp for one request
function automatic rdbuf_pkg::bank_data_t ref_data(
    input rdbuf_pkg::entry_idx_t idx,
    input rdbuf_pkg::ctmask_t    mask
);
    rdbuf_pkg::bank_data_t d;
    d = '0;
    for (int b = 0; b < rdbuf_pkg::BANK_NUM; b++) begin
        if (mask[b]) begin
            d = d | model_data[b][idx];
        end
    end
    return d;
endfunction

function automatic rdbuf_pkg::resp_t ref_resp(
    input rdbuf_pkg::entry_idx_t idx,
    input rdbuf_pkg::ctmask_t    mask
);
    rdbuf_pkg::resp_t r;
    r = '0;
    for (int b = 0; b < rdbuf_pkg::BANK_NUM; b++) begin
        if (mask[b]) begin
            r = r | model_resp[b][idx];
        end
    end
    return r;
endfunction

`endif

// ==== test/tb_rdbuf.sv ====
// --------------------------------------------------------------------------
// inputs change on the rising edge, outputs are sampled on the falling edge
// every R beat is checked in order against the bank model
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_rdbuf;

    logic                   clk_i;
    logic                   rst_i;
    logic                   flit_valid_i;
    rdbuf_pkg::flit_t       flit_i;
    logic                   flit_valid_o;
    rdbuf_pkg::txnid_t      flit_txnid_o;
    rdbuf_pkg::dataid_t     flit_dataid_o;
    logic                   req_valid_i;
    rdbuf_pkg::entry_idx_t  req_idx_i;
    rdbuf_pkg::ctmask_t     req_ctmask_i;
    logic                   req_last_i;
    rdbuf_pkg::rid_t        req_rid_i;
    rdbuf_pkg::bcount_t     req_bcount_i;
    logic                   req_accept_o;
    logic                   r_ready_i;
    logic                   r_valid_o;
    rdbuf_pkg::rid_t        r_id_o;
    rdbuf_pkg::bank_data_t  r_data_o;
    rdbuf_pkg::resp_t       r_resp_o;
    logic                   r_last_o;

    integer seed;
    integer ready_seed;
    int     ready_mode;
    int     errors;
    int     checks;
    int     tests;
    int     errors_base;

    rdbuf_pkg::rid_t        exp_id   [$];
    rdbuf_pkg::bank_data_t  exp_data [$];
    rdbuf_pkg::resp_t       exp_resp [$];
    logic                   exp_last [$];

    `include "rdbuf_ref.svh"

    rdbuf_top u_rdbuf_top (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .flit_valid_i  (flit_valid_i),
        .flit_i        (flit_i),
        .flit_valid_o  (flit_valid_o),
        .flit_txnid_o  (flit_txnid_o),
        .flit_dataid_o (flit_dataid_o),
        .req_valid_i   (req_valid_i),
        .req_idx_i     (req_idx_i),
        .req_ctmask_i  (req_ctmask_i),
        .req_last_i    (req_last_i),
        .req_rid_i     (req_rid_i),
        .req_bcount_i  (req_bcount_i),
        .req_accept_o  (req_accept_o),
        .r_ready_i     (r_ready_i),
        .r_valid_o     (r_valid_o),
        .r_id_o        (r_id_o),
        .r_data_o      (r_data_o),
        .r_resp_o      (r_resp_o),
        .r_last_o      (r_last_o)
    );

    always #2 clk_i = ~clk_i;

    // 0 always ready, 1 held low, 2 random
    always @(posedge clk_i) begin
        case (ready_mode)
            1:       r_ready_i <= 1'b0;
            2:       r_ready_i <= 1'($random(ready_seed));
            default: r_ready_i <= 1'b1;
        endcase
    end

    task automatic set_ready_mode(input int mode);
        @(negedge clk_i);
        ready_mode = mode;
    endtask

    task automatic check_rid(input rdbuf_pkg::rid_t got, input rdbuf_pkg::rid_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0t: r_id_o is %h, expected %h", $time, got, exp);
        end
    endtask

    task automatic check_data(input rdbuf_pkg::bank_data_t got,
                              input rdbuf_pkg::bank_data_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0t: r_data_o is %h, expected %h", $time, got, exp);
        end
    endtask

    task automatic check_resp(input rdbuf_pkg::resp_t got, input rdbuf_pkg::resp_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0t: r_resp_o is %h, expected %h", $time, got, exp);
        end
    endtask

    task automatic check_txnid(input rdbuf_pkg::txnid_t got, input rdbuf_pkg::txnid_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0t: flit_txnid_o is %h, expected %h", $time, got, exp);
        end
    endtask

    task automatic check_dataid(input rdbuf_pkg::dataid_t got,
                                input rdbuf_pkg::dataid_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0t: flit_dataid_o is %h, expected %h", $time, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string name);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0t: %s is %b, expected %b", $time, name, got, exp);
        end
    endtask

    function automatic rdbuf_pkg::chi_data_t rand_chi_data();
        rdbuf_pkg::chi_data_t d;
        for (int w = 0; w < rdbuf_pkg::CHI_DATA_W / 32; w++) begin
            d[w*32 +: 32] = $random(seed);
        end
        return d;
    endfunction

    // one expected beat per copy, last only on the final one
    task automatic queue_expected(input rdbuf_pkg::entry_idx_t idx,
                                  input rdbuf_pkg::ctmask_t mask,
                                  input rdbuf_pkg::rid_t rid,
                                  input logic last,
                                  input rdbuf_pkg::bcount_t bcount);
        for (int n = 0; n <= bcount; n++) begin
            exp_id.push_back(rid);
            exp_data.push_back(ref_data(idx, mask));
            exp_resp.push_back(ref_resp(idx, mask));
            exp_last.push_back(last && (n == bcount));
        end
    endtask

    task automatic send_flit(input rdbuf_pkg::txnid_t txnid,
                             input rdbuf_pkg::dataid_t dataid,
                             input rdbuf_pkg::resp_t resp,
                             input rdbuf_pkg::chi_data_t data);
        @(posedge clk_i);
        flit_valid_i <= 1'b1;
        flit_i       <= {data, resp, dataid, txnid};
        model_write(txnid, dataid, resp, data);
        @(negedge clk_i);
        check_flag(flit_valid_o, 1'b1, "flit_valid_o");
        check_txnid(flit_txnid_o, txnid);
        check_dataid(flit_dataid_o, dataid);
        @(posedge clk_i);
        flit_valid_i <= 1'b0;
    endtask

    task automatic do_request(input rdbuf_pkg::entry_idx_t idx,
                              input rdbuf_pkg::ctmask_t mask,
                              input logic last,
                              input rdbuf_pkg::rid_t rid,
                              input rdbuf_pkg::bcount_t bcount,
                              input int max_cycles,
                              input logic must_accept,
                              output logic accepted);
        int waited;
        accepted = 1'b0;
        waited   = 0;
        @(posedge clk_i);
        req_valid_i  <= 1'b1;
        req_idx_i    <= idx;
        req_ctmask_i <= mask;
        req_last_i   <= last;
        req_rid_i    <= rid;
        req_bcount_i <= bcount;
        while (!accepted && waited < max_cycles) begin
            @(negedge clk_i);
            if (req_accept_o) begin
                accepted = 1'b1;
                queue_expected(idx, mask, rid, last, bcount);
            end
            @(posedge clk_i);
            waited++;
        end
        req_valid_i <= 1'b0;
        if (must_accept && !accepted) begin
            errors++;
            $display("request for slot %0d was not accepted within %0d cycles",
                     idx, max_cycles);
        end
    endtask

    task automatic wait_drain(input int max_cycles);
        int waited;
        waited = 0;
        while ((exp_id.size() != 0 || r_valid_o) && waited < max_cycles) begin
            @(negedge clk_i);
            waited++;
        end
        if (exp_id.size() != 0 || r_valid_o) begin
            errors++;
            $display("R channel did not drain within %0d cycles, %0d beats still expected",
                     max_cycles, exp_id.size());
        end
    endtask

    task automatic finish_test(input string name);
        tests++;
        $display("test %0d %s finished with %0d errors", tests, name, errors - errors_base);
        errors_base = errors;
    endtask

    // a transfer shows on the falling edge before its clock edge
    initial begin
        forever begin
            @(negedge clk_i);
            if (!rst_i && r_valid_o && r_ready_i) begin
                if (exp_id.size() == 0) begin
                    errors++;
                    $display("an R beat with id %h arrived when none was expected", r_id_o);
                end else begin
                    check_rid(r_id_o, exp_id.pop_front());
                    check_data(r_data_o, exp_data.pop_front());
                    check_resp(r_resp_o, exp_resp.pop_front());
                    check_flag(r_last_o, exp_last.pop_front(), "r_last_o");
                end
            end
        end
    end

    initial begin
        logic                 ok;
        logic                 dropped;
        rdbuf_pkg::txnid_t    txnid;
        rdbuf_pkg::ctmask_t   mask;

        clk_i        = 1'b0;
        rst_i        = 1'b1;
        flit_valid_i = 1'b0;
        flit_i       = '0;
        req_valid_i  = 1'b0;
        req_idx_i    = '0;
        req_ctmask_i = '0;
        req_last_i   = 1'b0;
        req_rid_i    = '0;
        req_bcount_i = '0;
        r_ready_i    = 1'b0;
        seed         = 13;
        ready_seed   = 13;
        ready_mode   = 0;
        errors       = 0;
        checks       = 0;
        tests        = 0;
        errors_base  = 0;
        model_clear();

        repeat (5) @(posedge clk_i);
        rst_i <= 1'b0;
        @(negedge clk_i);
        check_flag(r_valid_o, 1'b0, "r_valid_o after reset");
        check_flag(req_accept_o, 1'b0, "req_accept_o after reset");
        check_flag(flit_valid_o, 1'b0, "flit_valid_o with no flit");

        send_flit(12'h7c1, 2'd3, 2'd0, rand_chi_data());
        send_flit(12'h012, 2'd1, 2'd3, rand_chi_data());
        finish_test("flit id forwarding");

        send_flit(12'h0a5, 2'd0, 2'd1, rand_chi_data());
        send_flit(12'h0a5, 2'd2, 2'd2, rand_chi_data());
        for (int b = 0; b < rdbuf_pkg::BANK_NUM; b++) begin
            do_request(3'd5, rdbuf_pkg::ctmask_t'(1 << b), 1'b1, rdbuf_pkg::rid_t'(b),
                       '0, 32, 1'b1, ok);
        end
        wait_drain(200);
        finish_test("one-hot bank reads");

        do_request(3'd5, 4'b0011, 1'b1, 4'h9, 4'd3, 32, 1'b1, ok);
        do_request(3'd5, 4'b1100, 1'b0, 4'ha, 4'd2, 32, 1'b1, ok);
        wait_drain(200);
        finish_test("beat repeat and last");

        do_request(3'd5, 4'b0000, 1'b1, 4'h3, 4'd0, 12, 1'b0, ok);
        checks++;
        if (ok) begin
            errors++;
            $display("a request with an empty mask was accepted");
        end
        wait_drain(200);
        finish_test("zero mask");

        set_ready_mode(1);
        dropped = 1'b0;
        for (int i = 0; i < 16 && !dropped; i++) begin
            do_request(3'd5, 4'b0101, 1'(i), rdbuf_pkg::rid_t'(i), 4'd1, 8, 1'b0, ok);
            dropped = !ok;
        end
        checks++;
        if (!dropped) begin
            errors++;
            $display("req_accept_o never dropped while r_ready_i was held low");
        end
        set_ready_mode(0);
        wait_drain(200);
        finish_test("back-pressure");

        // fill every slot so that random reads only see written data
        for (int e = 0; e < rdbuf_pkg::ENTRY_NUM; e++) begin
            txnid = rdbuf_pkg::txnid_t'($random(seed));
            txnid[rdbuf_pkg::ENTRY_IDX_W-1:0] = rdbuf_pkg::entry_idx_t'(e);
            send_flit(txnid, 2'd0, rdbuf_pkg::resp_t'($random(seed)), rand_chi_data());
            send_flit(txnid, 2'd2, rdbuf_pkg::resp_t'($random(seed)), rand_chi_data());
        end
        set_ready_mode(2);
        for (int n = 0; n < 60; n++) begin
            if ($unsigned($random(seed)) % 3 == 0) begin
                send_flit(rdbuf_pkg::txnid_t'($random(seed)),
                          rdbuf_pkg::dataid_t'($random(seed)),
                          rdbuf_pkg::resp_t'($random(seed)), rand_chi_data());
            end else begin
                mask = rdbuf_pkg::ctmask_t'($random(seed));
                if (mask == '0) begin
                    mask = 4'b1000;
                end
                do_request(rdbuf_pkg::entry_idx_t'($random(seed)), mask, 1'($random(seed)),
                           rdbuf_pkg::rid_t'($random(seed)),
                           rdbuf_pkg::bcount_t'($unsigned($random(seed)) % 4),
                           64, 1'b1, ok);
            end
        end
        wait_drain(1000);
        set_ready_mode(0);
        finish_test("random traffic");

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+test
rtl/rdbuf_pkg.sv
rtl/rdbuf_flit_decode.sv
rtl/rdbuf_data_store.sv
rtl/rdbuf_fifo.sv
rtl/rdbuf_beat_issue.sv
rtl/rdbuf_top.sv
test/tb_rdbuf.sv

// ==== Bender.yml ====
package:
  name: rdbuf

sources:
  - rtl/rdbuf_pkg.sv
  - rtl/rdbuf_flit_decode.sv
  - rtl/rdbuf_data_store.sv
  - rtl/rdbuf_fifo.sv
  - rtl/rdbuf_beat_issue.sv
  - rtl/rdbuf_top.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/tb_rdbuf.sv
